// ==== design/pcie_queue_pkg.sv ====
package pcie_queue_pkg;

// queue table geometry
localparam int app_idx_width     = 2;
localparam int queue_table_depth = 2 ** app_idx_width;
localparam int reg_width         = 32;
localparam int rb_awidth         = 32;
localparam int kmem_width        = 2 * reg_width;

// host register page
localparam int pcie_addr_width = 16;
localparam int page_lsb        = 12;
localparam int dwords_per_word = 16;
localparam int page_word_width = dwords_per_word * reg_width;
localparam int bytes_per_dword = reg_width / 8;
localparam int byteen_width    = page_word_width / 8;

// dword offsets inside a page, also the order of the table fields
localparam int reg_tail     = 0;
localparam int reg_head     = 1;
localparam int reg_kmem_lo  = 2;
localparam int reg_kmem_hi  = 3;
localparam int table_fields = 4;

// status bus
localparam int stat_addr_width = 30;
localparam int stat_awidth     = 4;
localparam logic [stat_awidth-1:0] stat_block_pcie = 'd2;
localparam int rb_size_width   = 26;

// queue switch and tail write-back machine
typedef enum logic [2:0] {
    IDLE,
    WAIT_DMA,
    RAM_DELAY_1,
    RAM_DELAY_2,
    SWITCH_QUEUE
} ctx_state_e;

// one 512-bit host word, seen as raw dwords or as the queue registers
typedef union packed {
    logic [dwords_per_word-1:0][reg_width-1:0] dw;
    struct packed {
        logic [page_word_width-table_fields*reg_width-1:0] pad;
        logic [reg_width-1:0] kmem_hi;
        logic [reg_width-1:0] kmem_lo;
        logic [reg_width-1:0] head;
        logic [reg_width-1:0] tail;
    } f;
} page_word_u;

// a dword counts as written only with all of its byte enables set
function automatic logic dword_full(
    input logic [byteen_width-1:0] be,
    input int                      idx
);
    return &be[idx*bytes_per_dword +: bytes_per_dword];
endfunction

endpackage

// ==== design/queue_table_ram.sv ====
`timescale 1ns/100ps

module queue_table_ram
    import pcie_queue_pkg::*;
#(
    parameter int data_width = reg_width
) (
    input  logic                     clock,
    input  logic [app_idx_width-1:0] address_a,
    input  logic [app_idx_width-1:0] address_b,
    input  logic [data_width-1:0]    data_a,
    input  logic [data_width-1:0]    data_b,
    input  logic                     rden_a,
    input  logic                     rden_b,
    input  logic                     wren_a,
    input  logic                     wren_b,
    output logic [data_width-1:0]    q_a,
    output logic [data_width-1:0]    q_b
);

logic [data_width-1:0]    mem [queue_table_depth];
logic [app_idx_width-1:0] address_a_r;
logic [app_idx_width-1:0] address_b_r;
logic                     rden_a_r;
logic                     rden_b_r;

// port b wins when both ports write the same entry
always_ff @(posedge clock) begin
    if (wren_a) begin
        mem[address_a] <= data_a;
    end
    if (wren_b) begin
        mem[address_b] <= data_b;
    end
end

// address stage, then output stage: data two cycles after rden
always_ff @(posedge clock) begin
    address_a_r <= address_a;
    address_b_r <= address_b;
    rden_a_r    <= rden_a;
    rden_b_r    <= rden_b;
    if (rden_a_r) begin
        q_a <= mem[address_a_r];
    end
    if (rden_b_r) begin
        q_b <= mem[address_b_r];
    end
end

endmodule

// ==== design/queue_table.sv ====
`timescale 1ns/100ps

module queue_table
    import pcie_queue_pkg::*;
(
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // host register page
    input  logic [pcie_addr_width-1:0] pcie_address,
    input  logic                       pcie_write,
    input  logic                       pcie_read,
    input  logic [page_word_width-1:0] pcie_writedata,
    input  logic [byteen_width-1:0]    pcie_byteenable,
    output logic [page_word_width-1:0] pcie_readdata,
    output logic                       pcie_readdatavalid,

    // port a, owned by the queue context
    input  logic [app_idx_width-1:0]   ctx_queue,
    input  logic                       ctx_rd_en,
    input  logic                       ctx_wr_en,
    input  logic [reg_width-1:0]       ctx_tail_wr_data,
    output logic [reg_width-1:0]       ctx_tail,
    output logic [reg_width-1:0]       ctx_head,
    output logic [kmem_width-1:0]      ctx_kmem
);

logic [app_idx_width-1:0] page_idx;
page_word_u               wr_word;
page_word_u               rd_word;

// single outstanding host read
logic [app_idx_width-1:0] rd_page;
logic                     rd_pending;
logic                     rd_issue;
logic                     rd_issue_r1;
logic                     rd_issue_r2;

logic [app_idx_width-1:0]               addr_b;
logic [table_fields-1:0]                wren_a;
logic [table_fields-1:0]                wren_b;
logic [table_fields-1:0][reg_width-1:0] q_a;
logic [table_fields-1:0][reg_width-1:0] q_b;

assign page_idx = pcie_address[page_lsb +: app_idx_width];
assign wr_word  = pcie_writedata;

// port b is shared, host writes go first and the pending read waits
assign rd_issue = rd_pending && !pcie_write;
assign addr_b   = pcie_write ? page_idx : rd_page;

for (genvar i = 0; i < table_fields; i++) begin : g_field
    // only the tail entry is written back through port a
    assign wren_a[i] = ctx_wr_en && (i == reg_tail);
    // the tail belongs to the dma side, host writes never reach it
    assign wren_b[i] = pcie_write && dword_full(pcie_byteenable, i) && (i != reg_tail);

    queue_table_ram #(
        .data_width (reg_width)
    ) u_ram (
        .clock     (pcie_clk),
        .address_a (ctx_queue),
        .address_b (addr_b),
        .data_a    (ctx_tail_wr_data),
        .data_b    (wr_word.dw[i]),
        .rden_a    (ctx_rd_en),
        .rden_b    (rd_issue),
        .wren_a    (wren_a[i]),
        .wren_b    (wren_b[i]),
        .q_a       (q_a[i]),
        .q_b       (q_b[i])
    );
end

assign ctx_tail = q_a[reg_tail];
assign ctx_head = q_a[reg_head];
assign ctx_kmem = {q_a[reg_kmem_hi], q_a[reg_kmem_lo]};

// response word, upper dwords read as zero
always_comb begin
    rd_word           = '0;
    rd_word.f.tail    = q_b[reg_tail];
    rd_word.f.head    = q_b[reg_head];
    rd_word.f.kmem_lo = q_b[reg_kmem_lo];
    rd_word.f.kmem_hi = q_b[reg_kmem_hi];
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rd_pending         <= 1'b0;
        rd_issue_r1        <= 1'b0;
        rd_issue_r2        <= 1'b0;
        pcie_readdatavalid <= 1'b0;
    end else begin
        rd_issue_r1        <= rd_issue;
        rd_issue_r2        <= rd_issue_r1;
        pcie_readdatavalid <= rd_issue_r2;
        if (pcie_read) begin
            rd_pending <= 1'b1;
        end else if (rd_issue) begin
            rd_pending <= 1'b0;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (pcie_read) begin
        rd_page <= page_idx;
    end
    // table data is on q_b two cycles after issue
    if (rd_issue_r2) begin
        pcie_readdata <= rd_word;
    end
end

endmodule

// ==== design/queue_context.sv ====
`timescale 1ns/100ps

module queue_context
    import pcie_queue_pkg::*;
(
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // host writes to the register pages
    input  logic [pcie_addr_width-1:0] pcie_address,
    input  logic                       pcie_write,
    input  logic [page_word_width-1:0] pcie_writedata,
    input  logic [byteen_width-1:0]    pcie_byteenable,

    // dma engine
    input  logic                       dma_start,
    input  logic [app_idx_width-1:0]   dma_queue,
    input  logic                       dma_done,
    input  logic [rb_awidth-1:0]       new_tail,
    output logic [rb_awidth-1:0]       f2c_head,
    output logic [rb_awidth-1:0]       f2c_tail,
    output logic [kmem_width-1:0]      f2c_kmem_addr,
    output logic                       f2c_queue_ready,

    // queue table port a
    output logic [app_idx_width-1:0]   ctx_queue,
    output logic                       ctx_rd_en,
    output logic                       ctx_wr_en,
    output logic [reg_width-1:0]       ctx_tail_wr_data,
    input  logic [reg_width-1:0]       ctx_tail,
    input  logic [reg_width-1:0]       ctx_head,
    input  logic [kmem_width-1:0]      ctx_kmem
);

logic [app_idx_width-1:0] page_idx;
page_word_u               wr_word;
logic                     active_write;
ctx_state_e               state;

// msb set means no queue is loaded yet
logic [app_idx_width:0]   queue_id;

assign page_idx     = pcie_address[page_lsb +: app_idx_width];
assign wr_word      = pcie_writedata;
assign active_write = pcie_write && ({1'b0, page_idx} == queue_id);

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        state           <= IDLE;
        queue_id        <= '1;
        f2c_queue_ready <= 1'b0;
        ctx_rd_en       <= 1'b0;
        ctx_wr_en       <= 1'b0;
        f2c_head        <= '0;
        f2c_tail        <= '0;
        f2c_kmem_addr   <= '0;
    end else begin
        f2c_queue_ready <= 1'b0;
        ctx_rd_en       <= 1'b0;
        ctx_wr_en       <= 1'b0;

        // host updates to the active queue go straight to the live copy
        if (active_write) begin
            if (dword_full(pcie_byteenable, reg_tail)) begin
                f2c_tail <= wr_word.dw[reg_tail];
            end
            if (dword_full(pcie_byteenable, reg_head)) begin
                f2c_head <= wr_word.dw[reg_head];
            end
            if (dword_full(pcie_byteenable, reg_kmem_lo)) begin
                f2c_kmem_addr[reg_width-1:0] <= wr_word.dw[reg_kmem_lo];
            end
            if (dword_full(pcie_byteenable, reg_kmem_hi)) begin
                f2c_kmem_addr[kmem_width-1:reg_width] <= wr_word.dw[reg_kmem_hi];
            end
        end

        case (state)
            IDLE: begin
                if (dma_start) begin
                    if ({1'b0, dma_queue} == queue_id) begin
                        f2c_queue_ready <= 1'b1;
                        state           <= WAIT_DMA;
                    end else begin
                        // fetch the new queue from the table
                        ctx_queue <= dma_queue;
                        ctx_rd_en <= 1'b1;
                        state     <= RAM_DELAY_1;
                    end
                end
            end
            WAIT_DMA: begin
                if (dma_done) begin
                    f2c_tail         <= new_tail;
                    ctx_queue        <= queue_id[app_idx_width-1:0];
                    ctx_tail_wr_data <= new_tail;
                    ctx_wr_en        <= 1'b1;
                    state            <= IDLE;
                end
            end
            RAM_DELAY_1: begin
                state <= RAM_DELAY_2;
            end
            RAM_DELAY_2: begin
                state <= SWITCH_QUEUE;
            end
            SWITCH_QUEUE: begin
                // ctx_queue still holds the queue being loaded
                f2c_tail        <= ctx_tail;
                f2c_head        <= ctx_head;
                f2c_kmem_addr   <= ctx_kmem;
                queue_id        <= {1'b0, ctx_queue};
                f2c_queue_ready <= 1'b1;
                state           <= WAIT_DMA;
            end
            default: begin
                state <= IDLE;
            end
        endcase
    end
end

endmodule

// ==== design/status_regs.sv ====
`timescale 1ns/100ps

module status_regs
    import pcie_queue_pkg::*;
(
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic [stat_addr_width-1:0] status_addr,
    input  logic                       status_read,
    input  logic                       status_write,
    input  logic [reg_width-1:0]       status_writedata,
    output logic [reg_width-1:0]       status_readdata,
    output logic                       status_readdata_valid,
    output logic                       disable_pcie,
    output logic [rb_size_width-1:0]   rb_size
);

logic [stat_addr_width-1:0] status_addr_r;
logic                       status_read_r;
logic                       status_write_r;
logic [reg_width-1:0]       status_writedata_r;
logic [reg_width-1:0]       control_reg;
logic                       block_hit;
logic                       ctrl_hit;

// top bits pick the block, the rest is the register offset
assign block_hit = status_addr_r[stat_addr_width-1 -: stat_awidth] == stat_block_pcie;
assign ctrl_hit  = block_hit && (status_addr_r[stat_addr_width-stat_awidth-1:0] == '0);

always_ff @(posedge pcie_clk) begin
    status_addr_r      <= status_addr;
    status_writedata_r <= status_writedata;
    if (ctrl_hit && status_read_r) begin
        status_readdata <= control_reg;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        status_read_r         <= 1'b0;
        status_write_r        <= 1'b0;
        status_readdata_valid <= 1'b0;
        control_reg           <= '0;
    end else begin
        status_read_r  <= status_read;
        status_write_r <= status_write;
        // other offsets stay silent
        status_readdata_valid <= ctrl_hit && status_read_r;
        if (ctrl_hit && status_write_r) begin
            control_reg <= status_writedata_r;
        end
    end
end

assign disable_pcie = control_reg[0];
assign rb_size      = control_reg[rb_size_width:1];

endmodule

// ==== design/pcie_queue_top.sv ====
`timescale 1ns/100ps

module pcie_queue_top
    import pcie_queue_pkg::*;
(
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // host port
    input  logic [pcie_addr_width-1:0] pcie_address,
    input  logic                       pcie_write,
    input  logic                       pcie_read,
    input  logic [page_word_width-1:0] pcie_writedata,
    input  logic [byteen_width-1:0]    pcie_byteenable,
    output logic [page_word_width-1:0] pcie_readdata,
    output logic                       pcie_readdatavalid,

    // dma engine
    input  logic                       dma_start,
    input  logic [app_idx_width-1:0]   dma_queue,
    input  logic                       dma_done,
    input  logic [rb_awidth-1:0]       new_tail,
    output logic [rb_awidth-1:0]       f2c_head,
    output logic [rb_awidth-1:0]       f2c_tail,
    output logic [kmem_width-1:0]      f2c_kmem_addr,
    output logic                       f2c_queue_ready,

    // status bus
    input  logic [stat_addr_width-1:0] status_addr,
    input  logic                       status_read,
    input  logic                       status_write,
    input  logic [reg_width-1:0]       status_writedata,
    output logic [reg_width-1:0]       status_readdata,
    output logic                       status_readdata_valid,
    output logic                       disable_pcie,
    output logic [rb_size_width-1:0]   rb_size
);

logic [app_idx_width-1:0] ctx_queue;
logic                     ctx_rd_en;
logic                     ctx_wr_en;
logic [reg_width-1:0]     ctx_tail_wr_data;
logic [reg_width-1:0]     ctx_tail;
logic [reg_width-1:0]     ctx_head;
logic [kmem_width-1:0]    ctx_kmem;

queue_table u_queue_table (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pcie_address       (pcie_address),
    .pcie_write         (pcie_write),
    .pcie_read          (pcie_read),
    .pcie_writedata     (pcie_writedata),
    .pcie_byteenable    (pcie_byteenable),
    .pcie_readdata      (pcie_readdata),
    .pcie_readdatavalid (pcie_readdatavalid),
    .ctx_queue          (ctx_queue),
    .ctx_rd_en          (ctx_rd_en),
    .ctx_wr_en          (ctx_wr_en),
    .ctx_tail_wr_data   (ctx_tail_wr_data),
    .ctx_tail           (ctx_tail),
    .ctx_head           (ctx_head),
    .ctx_kmem           (ctx_kmem)
);

queue_context u_queue_context (
    .pcie_clk         (pcie_clk),
    .pcie_reset_n     (pcie_reset_n),
    .pcie_address     (pcie_address),
    .pcie_write       (pcie_write),
    .pcie_writedata   (pcie_writedata),
    .pcie_byteenable  (pcie_byteenable),
    .dma_start        (dma_start),
    .dma_queue        (dma_queue),
    .dma_done         (dma_done),
    .new_tail         (new_tail),
    .f2c_head         (f2c_head),
    .f2c_tail         (f2c_tail),
    .f2c_kmem_addr    (f2c_kmem_addr),
    .f2c_queue_ready  (f2c_queue_ready),
    .ctx_queue        (ctx_queue),
    .ctx_rd_en        (ctx_rd_en),
    .ctx_wr_en        (ctx_wr_en),
    .ctx_tail_wr_data (ctx_tail_wr_data),
    .ctx_tail         (ctx_tail),
    .ctx_head         (ctx_head),
    .ctx_kmem         (ctx_kmem)
);

status_regs u_status_regs (
    .pcie_clk              (pcie_clk),
    .pcie_reset_n          (pcie_reset_n),
    .status_addr           (status_addr),
    .status_read           (status_read),
    .status_write          (status_write),
    .status_writedata      (status_writedata),
    .status_readdata       (status_readdata),
    .status_readdata_valid (status_readdata_valid),
    .disable_pcie          (disable_pcie),
    .rb_size               (rb_size)
);

endmodule

// ==== sim/pcie_queue_assert.sv ====
`timescale 1ns/100ps

module pcie_queue_assert
    import pcie_queue_pkg::*;
(
    input logic                       pcie_clk,
    input logic                       pcie_reset_n,
    input logic                       pcie_read,
    input logic                       pcie_readdatavalid,
    input logic                       dma_start,
    input logic [app_idx_width-1:0]   dma_queue,
    input logic                       f2c_queue_ready,
    input logic [stat_addr_width-1:0] status_addr,
    input logic                       status_read,
    input logic                       status_readdata_valid,
    input logic                       disable_pcie,
    input logic [rb_size_width-1:0]   rb_size,
    input ctx_state_e                 state,
    input logic [app_idx_width:0]     queue_id
);

int   fail_count = 0;
logic read_outstanding;
logic same_start;
logic switch_start;
logic ctrl_read;

assign same_start   = dma_start && (state == IDLE) && ({1'b0, dma_queue} == queue_id);
assign switch_start = dma_start && (state == IDLE) && ({1'b0, dma_queue} != queue_id);
assign ctrl_read    = status_read &&
    (status_addr == {stat_block_pcie, {(stat_addr_width - stat_awidth){1'b0}}});

// set by a host read, cleared by its response
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        read_outstanding <= 1'b0;
    end else if (pcie_read) begin
        read_outstanding <= 1'b1;
    end else if (pcie_readdatavalid) begin
        read_outstanding <= 1'b0;
    end
end

reset_quiet: assert property (@(posedge pcie_clk)
    !pcie_reset_n |=> !pcie_readdatavalid && !f2c_queue_ready && !status_readdata_valid
        && !disable_pcie && (rb_size == '0))
else begin
    $error("outputs active right after reset");
    fail_count++;
end

same_queue_grant: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    same_start |=> f2c_queue_ready)
else begin
    $error("same-queue grant not one cycle after dma_start");
    fail_count++;
end

switch_grant: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    switch_start |=> !f2c_queue_ready [*3] ##1 f2c_queue_ready)
else begin
    $error("queue switch grant not four cycles after dma_start");
    fail_count++;
end

status_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    ctrl_read |-> ##2 status_readdata_valid)
else begin
    $error("status read response not two cycles after the strobe");
    fail_count++;
end

read_min_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    pcie_read |=> !pcie_readdatavalid [*3])
else begin
    $error("host read response earlier than four cycles");
    fail_count++;
end

read_needs_request: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    pcie_readdatavalid |-> read_outstanding)
else begin
    $error("host read response without a pending read");
    fail_count++;
end

endmodule

bind pcie_queue_top pcie_queue_assert u_assert (
    .pcie_clk              (pcie_clk),
    .pcie_reset_n          (pcie_reset_n),
    .pcie_read             (pcie_read),
    .pcie_readdatavalid    (pcie_readdatavalid),
    .dma_start             (dma_start),
    .dma_queue             (dma_queue),
    .f2c_queue_ready       (f2c_queue_ready),
    .status_addr           (status_addr),
    .status_read           (status_read),
    .status_readdata_valid (status_readdata_valid),
    .disable_pcie          (disable_pcie),
    .rb_size               (rb_size),
    .state                 (u_queue_context.state),
    .queue_id              (u_queue_context.queue_id)
);

// ==== sim/tb_pcie_queue.sv ====
`timescale 1ns/100ps

module tb_pcie_queue
    import pcie_queue_pkg::*;
();

localparam int clk_period      = 40;
// the watchdog allows twice the summed cycle estimates of the tests
localparam int reset_cycles    = 8;
localparam int status_cycles   = 40;
localparam int dma_cycles      = (queue_table_depth + 1) * 40;
localparam int host_cycles     = 8 * 2 + queue_table_depth * 16;
localparam int burst_cycles    = 40;
localparam int watchdog_cycles =
    2 * (reset_cycles + status_cycles + dma_cycles + host_cycles + burst_cycles);

logic                       pcie_clk;
logic                       pcie_reset_n;
logic [pcie_addr_width-1:0] pcie_address;
logic                       pcie_write;
logic                       pcie_read;
logic [page_word_width-1:0] pcie_writedata;
logic [byteen_width-1:0]    pcie_byteenable;
logic [page_word_width-1:0] pcie_readdata;
logic                       pcie_readdatavalid;
logic                       dma_start;
logic [app_idx_width-1:0]   dma_queue;
logic                       dma_done;
logic [rb_awidth-1:0]       new_tail;
logic [rb_awidth-1:0]       f2c_head;
logic [rb_awidth-1:0]       f2c_tail;
logic [kmem_width-1:0]      f2c_kmem_addr;
logic                       f2c_queue_ready;
logic [stat_addr_width-1:0] status_addr;
logic                       status_read;
logic                       status_write;
logic [reg_width-1:0]       status_writedata;
logic [reg_width-1:0]       status_readdata;
logic                       status_readdata_valid;
logic                       disable_pcie;
logic [rb_size_width-1:0]   rb_size;

// reference copy of the queue table
logic [reg_width-1:0] model_tail    [queue_table_depth];
logic [reg_width-1:0] model_head    [queue_table_depth];
logic [reg_width-1:0] model_kmem_lo [queue_table_depth];
logic [reg_width-1:0] model_kmem_hi [queue_table_depth];
string                test_name;

pcie_queue_top dut0 (.*);

initial begin
    pcie_clk = 1'b0;
    forever begin
        #(clk_period / 2) pcie_clk = ~pcie_clk;
    end
end

task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
endtask

task automatic check_value(input logic [page_word_width-1:0] expected,
                           input logic [page_word_width-1:0] actual);
    assert (actual === expected) else begin
        fail_run($sformatf("mismatch in %s: expected %0h, actual %0h",
                           test_name, expected, actual));
    end
endtask

function automatic logic [page_word_width-1:0] model_page(input int page);
    return {{(page_word_width - table_fields * reg_width){1'b0}}, model_kmem_hi[page],
            model_kmem_lo[page], model_head[page], model_tail[page]};
endfunction

function automatic logic [page_word_width-1:0] random_word();
    logic [page_word_width-1:0] w;
    for (int i = 0; i < dwords_per_word; i++) begin
        w[i*reg_width +: reg_width] = $urandom;
    end
    return w;
endfunction

// each dword gets full, empty or partial enables
function automatic logic [byteen_width-1:0] random_enables();
    logic [byteen_width-1:0] be;
    int unsigned             pick;
    for (int i = 0; i < dwords_per_word; i++) begin
        pick = $urandom_range(2, 0);
        case (pick)
            0: be[i*bytes_per_dword +: bytes_per_dword] = '1;
            1: be[i*bytes_per_dword +: bytes_per_dword] = '0;
            default: be[i*bytes_per_dword +: bytes_per_dword] =
                bytes_per_dword'($urandom_range(14, 0));
        endcase
    end
    return be;
endfunction

task automatic host_write(input int page, input logic [page_word_width-1:0] data,
                          input logic [byteen_width-1:0] be, input logic with_read);
    @(posedge pcie_clk);
    pcie_address    <= pcie_addr_width'(page << page_lsb);
    pcie_write      <= 1'b1;
    pcie_read       <= with_read;
    pcie_writedata  <= data;
    pcie_byteenable <= be;
    // host writes never reach the table tail
    if (&be[reg_head*bytes_per_dword +: bytes_per_dword]) begin
        model_head[page] = data[reg_head*reg_width +: reg_width];
    end
    if (&be[reg_kmem_lo*bytes_per_dword +: bytes_per_dword]) begin
        model_kmem_lo[page] = data[reg_kmem_lo*reg_width +: reg_width];
    end
    if (&be[reg_kmem_hi*bytes_per_dword +: bytes_per_dword]) begin
        model_kmem_hi[page] = data[reg_kmem_hi*reg_width +: reg_width];
    end
endtask

task automatic bus_idle();
    @(posedge pcie_clk);
    pcie_write <= 1'b0;
    pcie_read  <= 1'b0;
endtask

task automatic await_read(input int page);
    int n;
    n = 0;
    @(negedge pcie_clk);
    while (!pcie_readdatavalid && n < 20) begin
        @(negedge pcie_clk);
        n++;
    end
    assert (pcie_readdatavalid) else begin
        fail_run($sformatf("%s: host read of page %0d got no response", test_name, page));
    end
    check_value(model_page(page), pcie_readdata);
endtask

task automatic host_read(input int page);
    @(posedge pcie_clk);
    pcie_address <= pcie_addr_width'(page << page_lsb);
    pcie_read    <= 1'b1;
    bus_idle();
    await_read(page);
endtask

task automatic dma_select(input int q, input logic check_tail);
    int n;
    n = 0;
    @(posedge pcie_clk);
    dma_start <= 1'b1;
    dma_queue <= q[app_idx_width-1:0];
    @(posedge pcie_clk);
    dma_start <= 1'b0;
    @(negedge pcie_clk);
    while (!f2c_queue_ready && n < 10) begin
        @(negedge pcie_clk);
        n++;
    end
    assert (f2c_queue_ready) else begin
        fail_run($sformatf("%s: queue %0d was never granted", test_name, q));
    end
    check_value(model_head[q], f2c_head);
    check_value({model_kmem_hi[q], model_kmem_lo[q]}, f2c_kmem_addr);
    if (check_tail) begin
        check_value(model_tail[q], f2c_tail);
    end
endtask

task automatic dma_finish(input int q, input logic [rb_awidth-1:0] tail);
    @(posedge pcie_clk);
    dma_done <= 1'b1;
    new_tail <= tail;
    @(posedge pcie_clk);
    dma_done <= 1'b0;
    model_tail[q] = tail;
    @(negedge pcie_clk);
    check_value(tail, f2c_tail);
endtask

task automatic status_store(input logic [stat_awidth-1:0] block,
                            input logic [reg_width-1:0] data);
    @(posedge pcie_clk);
    status_addr      <= {block, {(stat_addr_width - stat_awidth){1'b0}}};
    status_write     <= 1'b1;
    status_writedata <= data;
    @(posedge pcie_clk);
    status_write <= 1'b0;
endtask

task automatic status_check(input logic [reg_width-1:0] expected);
    int n;
    n = 0;
    @(posedge pcie_clk);
    status_addr <= {stat_block_pcie, {(stat_addr_width - stat_awidth){1'b0}}};
    status_read <= 1'b1;
    @(posedge pcie_clk);
    status_read <= 1'b0;
    @(negedge pcie_clk);
    while (!status_readdata_valid && n < 10) begin
        @(negedge pcie_clk);
        n++;
    end
    assert (status_readdata_valid) else begin
        fail_run($sformatf("%s: status read got no response", test_name));
    end
    check_value(expected, status_readdata);
    check_value(expected[0], disable_pcie);
    check_value(expected[rb_size_width:1], rb_size);
endtask

always @(negedge pcie_clk) begin
    if (dut0.u_assert.fail_count != 0) begin
        fail_run("a timing assertion on the DUT failed");
    end
end

initial begin
    #(watchdog_cycles * clk_period);
    fail_run("watchdog expired before the tests finished");
end

initial begin
    logic [reg_width-1:0]    ctrl_word;
    logic [byteen_width-1:0] no_tail_be;
    void'($urandom(32'hb55f_3830));
    pcie_reset_n     = 1'b0;
    pcie_address     = '0;
    pcie_write       = 1'b0;
    pcie_read        = 1'b0;
    pcie_writedata   = '0;
    pcie_byteenable  = '0;
    dma_start        = 1'b0;
    dma_queue        = '0;
    dma_done         = 1'b0;
    new_tail         = '0;
    status_addr      = '0;
    status_read      = 1'b0;
    status_write     = 1'b0;
    status_writedata = '0;
    repeat (reset_cycles) @(posedge pcie_clk);
    pcie_reset_n <= 1'b1;

    test_name = "status_control";
    ctrl_word = $urandom;
    status_store(stat_block_pcie, ctrl_word);
    status_check(ctrl_word);
    // another block on the status bus must not touch the register
    status_store(stat_block_pcie + 1'b1, ~ctrl_word);
    status_check(ctrl_word);

    test_name = "table_fill";
    for (int q = 0; q < queue_table_depth; q++) begin
        host_write(q, random_word(), '1, 1'b0);
    end
    bus_idle();

    test_name = "queue_switch";
    for (int q = 0; q < queue_table_depth; q++) begin
        dma_select(q, 1'b0);
        dma_finish(q, $urandom);
        dma_select(q, 1'b1);
        dma_finish(q, $urandom);
    end
    // every tail is known now so a switch also checks the tail loaded from the table
    dma_select(0, 1'b1);
    dma_finish(0, $urandom);
    dma_select(queue_table_depth - 1, 1'b1);
    dma_finish(queue_table_depth - 1, $urandom);

    test_name = "partial_write";
    repeat (8) begin
        host_write($urandom_range(queue_table_depth - 1, 0), random_word(),
                   random_enables(), 1'b0);
    end
    bus_idle();
    for (int q = 0; q < queue_table_depth; q++) begin
        host_read(q);
    end

    // the last queue loaded is still the active one
    test_name  = "active_write";
    no_tail_be = '0;
    no_tail_be[table_fields*bytes_per_dword-1:bytes_per_dword] = '1;
    host_write(queue_table_depth - 1, random_word(), no_tail_be, 1'b0);
    bus_idle();
    @(negedge pcie_clk);
    check_value(model_head[queue_table_depth-1], f2c_head);
    check_value({model_kmem_hi[queue_table_depth-1], model_kmem_lo[queue_table_depth-1]},
                f2c_kmem_addr);

    test_name = "read_in_burst";
    host_write(1, random_word(), random_enables(), 1'b1);
    host_write(0, random_word(), random_enables(), 1'b0);
    host_write(2, random_word(), random_enables(), 1'b0);
    host_write(1, random_word(), random_enables(), 1'b0);
    bus_idle();
    await_read(1);

    repeat (4) @(posedge pcie_clk);
    if (dut0.u_assert.fail_count == 0) begin
        $display("Everything OK");
        $finish;
    end else begin
        fail_run("a timing assertion on the DUT failed");
    end
end

endmodule

// ==== filelist.f ====
design/pcie_queue_pkg.sv
design/queue_table_ram.sv
design/queue_table.sv
design/queue_context.sv
design/status_regs.sv
design/pcie_queue_top.sv
sim/pcie_queue_assert.sv
sim/tb_pcie_queue.sv

// ==== Bender.yml ====
package:
  name: pcie_queue

sources:
  - design/pcie_queue_pkg.sv
  - design/queue_table_ram.sv
  - design/queue_table.sv
  - design/queue_context.sv
  - design/status_regs.sv
  - design/pcie_queue_top.sv
  - target: test
    files:
      - sim/pcie_queue_assert.sv
      - sim/tb_pcie_queue.sv
